//--- gear_loop_top.f
+incdir+dv
rtl/gear_pkg.sv
rtl/gear_csr.sv
rtl/gear_seq_fsm.sv
rtl/gear_burst_counter.sv
rtl/gear_pattern_src.sv
rtl/gearbox_2x1.sv
rtl/gear_loop_check.sv
rtl/gear_loop_top.sv
dv/gear_loop_tb.sv

//--- Bender.yml
package:
  name: gear_loop

sources:
  - files:
      - rtl/gear_pkg.sv
      - rtl/gear_csr.sv
      - rtl/gear_seq_fsm.sv
      - rtl/gear_burst_counter.sv
      - rtl/gear_pattern_src.sv
      - rtl/gearbox_2x1.sv
      - rtl/gear_loop_check.sv
      - rtl/gear_loop_top.sv

  - target: test
    include_dirs:
      - dv
    files:
      - dv/gear_loop_tb.sv

//--- dv/gear_tb_axil.svh
// AXI4-Lite bus and compare tasks

`ifndef GEAR_TB_AXIL_SVH
`define GEAR_TB_AXIL_SVH

// --------------------------------------------------------------------------
// Bus tasks, AW and W offered together, responses taken at once
// --------------------------------------------------------------------------

task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
  int wait_cnt;
  resp = 2'b11;
  @(posedge clk);
  axil_req.aw_valid <= 1'b1;
  axil_req.aw_addr  <= addr;
  axil_req.w_valid  <= 1'b1;
  axil_req.w_data   <= data;
  axil_req.w_strb   <= 4'hF;
  axil_req.b_ready  <= 1'b1;
  wait_cnt = 0;
  @(posedge clk);
  while (!axil_rsp.aw_ready && wait_cnt < WAIT_LIMIT) begin
    @(posedge clk);
    wait_cnt++;
  end
  axil_req.aw_valid <= 1'b0;
  axil_req.w_valid  <= 1'b0;
  if (!axil_rsp.aw_ready) begin
    $display("Timeout: write to 0x%02h was never accepted", addr);
    error_cnt++;
  end else begin
    wait_cnt = 0;
    @(posedge clk);
    while (!axil_rsp.b_valid && wait_cnt < WAIT_LIMIT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (!axil_rsp.b_valid) begin
      $display("Timeout: no write response for 0x%02h", addr);
      error_cnt++;
    end else begin
      resp = axil_rsp.b_resp;
    end
  end
  axil_req.b_ready <= 1'b0;
endtask

task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
  int wait_cnt;
  data = '0;
  resp = 2'b11;
  @(posedge clk);
  axil_req.ar_valid <= 1'b1;
  axil_req.ar_addr  <= addr;
  axil_req.r_ready  <= 1'b1;
  wait_cnt = 0;
  @(posedge clk);
  while (!axil_rsp.ar_ready && wait_cnt < WAIT_LIMIT) begin
    @(posedge clk);
    wait_cnt++;
  end
  axil_req.ar_valid <= 1'b0;
  if (!axil_rsp.ar_ready) begin
    $display("Timeout: read of 0x%02h was never accepted", addr);
    error_cnt++;
  end else begin
    wait_cnt = 0;
    @(posedge clk);
    while (!axil_rsp.r_valid && wait_cnt < WAIT_LIMIT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (!axil_rsp.r_valid) begin
      $display("Timeout: no read data for 0x%02h", addr);
      error_cnt++;
    end else begin
      data = axil_rsp.r_data;
      resp = axil_rsp.r_resp;
    end
  end
  axil_req.r_ready <= 1'b0;
endtask

// --------------------------------------------------------------------------
// Compare tasks, one per kind of result
// --------------------------------------------------------------------------

task automatic check_word(input string name, input word_t got, input word_t exp);
  check_cnt++;
  if (got !== exp) begin
    $display("FAIL %0t %s got 0x%04h expected 0x%04h", $time, name, got, exp);
    error_cnt++;
  end
endtask

task automatic check_count(input string name, input logic [15:0] got,
                           input logic [15:0] exp);
  check_cnt++;
  if (got !== exp) begin
    $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    error_cnt++;
  end
endtask

// Status bits are {timeout, done, busy}
task automatic check_status(input string name, input logic [2:0] got,
                            input logic [2:0] exp);
  check_cnt++;
  if (got !== exp) begin
    $display("FAIL %0t %s got 3'b%03b expected 3'b%03b", $time, name, got, exp);
    error_cnt++;
  end
endtask

task automatic check_resp(input string name, input logic [1:0] got,
                          input logic [1:0] exp);
  check_cnt++;
  if (got !== exp) begin
    $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    error_cnt++;
  end
endtask

`endif

//--- dv/gear_loop_tb.sv
// Gearbox loop testbench

`timescale 1ns/1ps

module gear_loop_tb import gear_pkg::*; ();

  localparam int WAIT_LIMIT = 50;
  localparam int POLL_LIMIT = 200;
  localparam int MAX_ROWS   = 16;

  // Settings of one burst and the results the loop should report
  typedef struct packed {
    logic [15:0] len;
    word_t       seed;
    logic        rand_seed;
    logic        corrupt;
    logic        restart;
    logic [15:0] exp_pairs;
    logic [15:0] exp_errors;
    logic        exp_timeout;
  } row_t;

  logic        clk;
  logic        clk_2x;
  logic        rst;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  gear_word_t  fast;

  int          error_cnt;
  int          check_cnt;
  int          test_cnt;
  int          errs_before;
  int          num_rows;
  int          row_idx;
  int unsigned rng_seed;
  row_t        rows [MAX_ROWS];
  row_t        cur;
  logic [31:0] rdata;
  logic [1:0]  resp;
  word_t       fast_q [$];

  `include "gear_tb_axil.svh"

  gear_loop_top #(
    .BIG_ENDIAN   (0),
    .DRAIN_CYCLES (32)
  ) i_dut (
    .i_clk    (clk),
    .i_clk_2x (clk_2x),
    .i_rst    (rst),
    .i_axil   (axil_req),
    .o_axil   (axil_rsp),
    .o_fast   (fast)
  );

  // 1x at 10 ns, 2x at 5 ns, rising edges line up
  always #5 clk = ~clk;
  always #2.5 clk_2x = ~clk_2x;

  // Fast-side words in arrival order
  always @(posedge clk_2x) begin
    if (!rst && fast.valid) fast_q.push_back(fast.data);
  end

  task automatic add_row(input logic [15:0] len, input word_t seed, input logic rand_seed,
                         input logic corrupt, input logic restart,
                         input logic [15:0] exp_pairs, input logic [15:0] exp_errors,
                         input logic exp_timeout);
    row_t r;
    r.len         = len;
    r.seed        = seed;
    r.rand_seed   = rand_seed;
    r.corrupt     = corrupt;
    r.restart     = restart;
    r.exp_pairs   = exp_pairs;
    r.exp_errors  = exp_errors;
    r.exp_timeout = exp_timeout;
    rows[num_rows] = r;
    num_rows++;
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    test_cnt++;
    $display("test %0d %s: %s", test_cnt, name,
             (error_cnt == errs_at_start) ? "ok" : "failed");
  endtask

  // --------------------------------------------------------------------------
  // Program and start one burst, poll for done, then check counters and words
  // --------------------------------------------------------------------------

  task automatic run_row(input row_t r);
    logic [31:0] data;
    logic [1:0]  rsp;
    int          polls;
    int          n;
    int          n_words;
    word_t       exp_w;
    fast_q.delete();
    axil_write(REG_SEED, {16'd0, r.seed}, rsp);
    check_resp("b_resp SEED", rsp, 2'b00);
    axil_write(REG_LEN, {16'd0, r.len}, rsp);
    check_resp("b_resp LEN", rsp, 2'b00);
    axil_write(REG_CTRL, {30'd0, r.corrupt, 1'b1}, rsp);
    // Second start lands while busy and must be dropped
    if (r.restart) axil_write(REG_CTRL, {30'd0, r.corrupt, 1'b1}, rsp);
    polls = 0;
    data  = '0;
    // S_DONE still shows busy for one cycle so wait for done with busy low
    while ((!data[1] || data[0]) && polls < POLL_LIMIT) begin
      axil_read(REG_STATUS, data, rsp);
      polls++;
    end
    if (!data[1] || data[0]) begin
      $display("Timeout: burst of %0d pairs never reported done", r.len);
      error_cnt++;
    end
    check_status("STATUS", data[2:0], {r.exp_timeout, 1'b1, 1'b0});
    axil_read(REG_PAIRS, data, rsp);
    check_count("PAIRS", data[15:0], r.exp_pairs);
    axil_read(REG_ERRORS, data, rsp);
    check_count("ERRORS", data[15:0], r.exp_errors);
    // Word n of the burst is seed plus n with bit 0 of the first flipped if corrupt
    n_words = 2 * r.exp_pairs;
    check_count("o_fast word count", 16'(fast_q.size()), 16'(n_words));
    for (n = 0; n < n_words && n < fast_q.size(); n++) begin
      exp_w = r.seed + word_t'(n);
      if (n == 0 && r.corrupt) exp_w[0] = ~exp_w[0];
      check_word("o_fast.data", fast_q[n], exp_w);
    end
  endtask

  initial begin
    rst       = 1'b1;
    axil_req  = '0;
    clk       = 1'b0;
    clk_2x    = 1'b1;
    error_cnt = 0;
    check_cnt = 0;
    test_cnt  = 0;
    num_rows  = 0;
    rng_seed  = 32'h41;
    void'($urandom(rng_seed));

    // len, seed, random seed, corrupt, restart, pairs, errors, timeout
    add_row(16'd1,   16'h0000, 1'b1, 1'b0, 1'b0, 16'd1,   16'd0, 1'b0);
    add_row(16'd4,   16'h0000, 1'b1, 1'b0, 1'b0, 16'd4,   16'd0, 1'b0);
    add_row(16'd100, 16'h0000, 1'b1, 1'b0, 1'b0, 16'd100, 16'd0, 1'b0);
    add_row(16'd4,   16'h0000, 1'b1, 1'b1, 1'b0, 16'd4,   16'd1, 1'b0);
    add_row(16'd100, 16'h0000, 1'b1, 1'b0, 1'b1, 16'd100, 16'd0, 1'b0);
    add_row(16'd6,   16'hFFFD, 1'b0, 1'b0, 1'b0, 16'd6,   16'd0, 1'b0);
    add_row(16'd0,   16'h1234, 1'b0, 1'b0, 1'b0, 16'd1,   16'd0, 1'b0);

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Idle after reset
    errs_before = error_cnt;
    fast_q.delete();
    axil_read(REG_STATUS, rdata, resp);
    check_status("STATUS", rdata[2:0], 3'b000);
    repeat (20) @(posedge clk);
    check_count("o_fast words while idle", 16'(fast_q.size()), 16'd0);
    report_test("idle after reset", errs_before);

    // Address outside the map
    errs_before = error_cnt;
    axil_write(8'h20, 32'h1, resp);
    check_resp("b_resp", resp, 2'b10);
    axil_read(8'h20, rdata, resp);
    check_resp("r_resp", resp, 2'b10);
    check_count("r_data", rdata[15:0], 16'd0);
    report_test("undefined address", errs_before);

    for (row_idx = 0; row_idx < num_rows; row_idx++) begin
      cur = rows[row_idx];
      if (cur.rand_seed) cur.seed = word_t'($urandom());
      errs_before = error_cnt;
      run_row(cur);
      report_test($sformatf("burst len %0d seed 0x%04h corrupt %0d restart %0d",
                            cur.len, cur.seed, cur.corrupt, cur.restart), errs_before);
    end

    $display("tests %0d  checks %0d  errors %0d", test_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- rtl/gear_loop_top.sv
// Gearbox self-test loop

`timescale 1ns/1ps

module gear_loop_top import gear_pkg::*; #(
  parameter int BIG_ENDIAN   = 0,
  parameter int DRAIN_CYCLES = 32
) (
  input  logic       i_clk,
  input  logic       i_clk_2x,
  input  logic       i_rst,
  input  axil_req_t  i_axil,
  output axil_rsp_t  o_axil,
  output gear_word_t o_fast
);

  // Control
  logic        start;
  logic        corrupt;
  logic [15:0] len;
  word_t       seed;
  logic        busy;
  logic        done;
  logic        timeout;
  logic [15:0] rx_pairs;
  logic [15:0] rx_errors;
  logic        cnt_load;
  logic [15:0] cnt_value;
  logic        cnt_en;
  logic        cnt_last;
  logic        src_load;
  logic        src_emit;
  logic        chk_clear;

  // Data path
  gear_pair_t          tx_pair;
  gear_pair_t          rx_pair;
  word_t               fast_data;
  logic                fast_valid;
  logic [2*WORD_W-1:0] rx_data;
  logic                rx_valid;

  gear_csr u_csr (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_axil    (i_axil),
    .o_axil    (o_axil),
    .o_start   (start),
    .o_corrupt (corrupt),
    .o_len     (len),
    .o_seed    (seed),
    .i_busy    (busy),
    .i_done    (done),
    .i_timeout (timeout),
    .i_pairs   (rx_pairs),
    .i_errors  (rx_errors)
  );

  gear_seq_fsm #(
    .DRAIN_CYCLES (DRAIN_CYCLES)
  ) u_fsm (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (start),
    .i_len       (len),
    .i_cnt_last  (cnt_last),
    .i_rx_pairs  (rx_pairs),
    .o_cnt_load  (cnt_load),
    .o_cnt_value (cnt_value),
    .o_cnt_en    (cnt_en),
    .o_src_load  (src_load),
    .o_src_emit  (src_emit),
    .o_chk_clear (chk_clear),
    .o_busy      (busy),
    .o_done      (done),
    .o_timeout   (timeout)
  );

  gear_burst_counter u_cnt (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_load  (cnt_load),
    .i_value (cnt_value),
    .i_en    (cnt_en),
    .o_last  (cnt_last)
  );

  gear_pattern_src #(
    .BIG_ENDIAN (BIG_ENDIAN)
  ) u_src (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_load    (src_load),
    .i_seed    (seed),
    .i_corrupt (corrupt),
    .i_emit    (src_emit),
    .o_pair    (tx_pair)
  );

  // 1x pairs out to the 2x word stream
  gearbox_2x1 #(
    .IN_WORDS   (2),
    .OUT_WORDS  (1),
    .BIG_ENDIAN (BIG_ENDIAN)
  ) u_gear_up (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_tdata   ({tx_pair.word1, tx_pair.word0}),
    .i_tvalid  (tx_pair.valid),
    .i_out_clk (i_clk_2x),
    .i_out_rst (i_rst),
    .o_tdata   (fast_data),
    .o_tvalid  (fast_valid)
  );

  assign o_fast = '{valid: fast_valid, data: fast_data};

  // And back into 1x pairs
  gearbox_2x1 #(
    .IN_WORDS   (1),
    .OUT_WORDS  (2),
    .BIG_ENDIAN (BIG_ENDIAN)
  ) u_gear_dn (
    .i_clk     (i_clk_2x),
    .i_rst     (i_rst),
    .i_tdata   (fast_data),
    .i_tvalid  (fast_valid),
    .i_out_clk (i_clk),
    .i_out_rst (i_rst),
    .o_tdata   (rx_data),
    .o_tvalid  (rx_valid)
  );

  assign rx_pair = '{
    valid: rx_valid,
    word1: rx_data[2*WORD_W-1:WORD_W],
    word0: rx_data[WORD_W-1:0]
  };

  gear_loop_check #(
    .BIG_ENDIAN (BIG_ENDIAN)
  ) u_check (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_clear  (chk_clear),
    .i_seed   (seed),
    .i_pair   (rx_pair),
    .o_pairs  (rx_pairs),
    .o_errors (rx_errors)
  );

endmodule

//--- rtl/gear_loop_check.sv
// Returned pattern checker

`timescale 1ns/1ps

module gear_loop_check import gear_pkg::*; #(
  parameter int BIG_ENDIAN = 0
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_clear,
  input  word_t       i_seed,
  input  gear_pair_t  i_pair,
  output logic [15:0] o_pairs,
  output logic [15:0] o_errors
);

  word_t       exp_q;
  word_t       first_w;
  word_t       second_w;
  logic        mismatch;
  logic [15:0] pairs_q;
  logic [15:0] errors_q;

  // Stream order out of the lanes
  assign first_w  = (BIG_ENDIAN != 0) ? i_pair.word1 : i_pair.word0;
  assign second_w = (BIG_ENDIAN != 0) ? i_pair.word0 : i_pair.word1;

  // Either word off counts the whole pair once
  assign mismatch = (first_w != exp_q) || (second_w != exp_q + word_t'(1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      exp_q    <= '0;
      pairs_q  <= '0;
      errors_q <= '0;
    end else if (i_clear) begin
      exp_q    <= i_seed;
      pairs_q  <= '0;
      errors_q <= '0;
    end else if (i_pair.valid) begin
      // Expected value runs on regardless of errors
      exp_q <= exp_q + word_t'(2);
      if (pairs_q != 16'hFFFF) begin
        pairs_q <= pairs_q + 16'd1;
      end
      if (mismatch && (errors_q != 16'hFFFF)) begin
        errors_q <= errors_q + 16'd1;
      end
    end
  end

  assign o_pairs  = pairs_q;
  assign o_errors = errors_q;

endmodule

//--- rtl/gearbox_2x1.sv
// 2:1 word-rate gearbox

`timescale 1ns/1ps

module gearbox_2x1 import gear_pkg::*; #(
  parameter int IN_WORDS   = 2,
  parameter int OUT_WORDS  = 1,
  parameter int BIG_ENDIAN = 0
) (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic [IN_WORDS*WORD_W-1:0]  i_tdata,
  input  logic                        i_tvalid,
  input  logic                        i_out_clk,
  input  logic                        i_out_rst,
  output logic [OUT_WORDS*WORD_W-1:0] o_tdata,
  output logic                        o_tvalid
);

  localparam int IN_W  = IN_WORDS * WORD_W;
  localparam int OUT_W = OUT_WORDS * WORD_W;

  // Only 2:1 in either direction
  if (!(IN_WORDS == 2 * OUT_WORDS || OUT_WORDS == 2 * IN_WORDS)) begin : g_bad_ratio
    $error("gearbox_2x1: IN_WORDS and OUT_WORDS must be 2:1 or 1:2");
  end

  // --------------------------------------------------------------------------
  // Slow to fast, one pair in per slow cycle, one word out per fast cycle
  // --------------------------------------------------------------------------

  if (IN_WORDS > OUT_WORDS) begin : g_up
    logic [IN_W-1:0] src_data_q;
    logic            src_valid_q;
    logic            src_tog_q;
    logic [IN_W-1:0] cap_data_q;
    logic            cap_valid_q;
    logic            cap_tog_q;
    logic            cap_tog_d_q;
    logic            lo_sel_q;

    always_ff @(posedge i_clk) begin
      src_data_q <= i_tdata;
    end

    // Toggle flips once per valid pair, marks its phase on the fast side
    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        src_valid_q <= 1'b0;
        src_tog_q   <= 1'b0;
      end else begin
        src_valid_q <= i_tvalid;
        src_tog_q   <= src_tog_q ^ i_tvalid;
      end
    end

    // Crossing, static timing assumed
    always_ff @(posedge i_out_clk) begin
      cap_data_q <= src_data_q;
    end

    always_ff @(posedge i_out_clk) begin
      if (i_out_rst) begin
        cap_valid_q <= 1'b0;
        cap_tog_q   <= 1'b0;
        cap_tog_d_q <= 1'b0;
        lo_sel_q    <= 1'b0;
        o_tvalid    <= 1'b0;
      end else begin
        cap_valid_q <= src_valid_q;
        cap_tog_q   <= src_tog_q;
        cap_tog_d_q <= cap_tog_q;
        // Steady toggle means the pair just arrived, first word due next
        lo_sel_q    <= (cap_tog_q == cap_tog_d_q) ^ (BIG_ENDIAN != 0);
        o_tvalid    <= cap_valid_q;
      end
    end

    // Half select
    always_ff @(posedge i_out_clk) begin
      o_tdata <= lo_sel_q ? cap_data_q[0 +: OUT_W] : cap_data_q[OUT_W +: OUT_W];
    end

  // --------------------------------------------------------------------------
  // Fast to slow, words joined into pairs
  // --------------------------------------------------------------------------

  end else begin : g_dn
    logic [IN_W-1:0]  hold_q;
    logic             hold_v_q;
    logic [OUT_W-1:0] join_q;
    logic             join_v_q;
    logic             join_v_d_q;
    logic [OUT_W-1:0] cap_data_q;
    logic             cap_v_q;

    // Keep the first word, join on the second
    always_ff @(posedge i_clk) begin
      if (i_tvalid) begin
        hold_q <= i_tdata;
      end
      if (i_tvalid && hold_v_q) begin
        join_q <= (BIG_ENDIAN != 0) ? {hold_q, i_tdata} : {i_tdata, hold_q};
      end
    end

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        hold_v_q   <= 1'b0;
        join_v_q   <= 1'b0;
        join_v_d_q <= 1'b0;
      end else begin
        if (i_tvalid) hold_v_q <= !hold_v_q;
        join_v_q   <= i_tvalid && hold_v_q;
        // Two fast cycles wide so one slow edge sees it
        join_v_d_q <= join_v_q;
      end
    end

    always_ff @(posedge i_out_clk) begin
      cap_data_q <= join_q;
      o_tdata    <= cap_data_q;
    end

    always_ff @(posedge i_out_clk) begin
      if (i_out_rst) begin
        cap_v_q  <= 1'b0;
        o_tvalid <= 1'b0;
      end else begin
        cap_v_q  <= join_v_q || join_v_d_q;
        o_tvalid <= cap_v_q;
      end
    end

    // A held word must be completed on the next fast cycle
    a_word_paired: assert property (@(posedge i_clk) disable iff (i_rst)
      hold_v_q |-> i_tvalid)
      else $error("gearbox_2x1: fast word without partner");
  end

endmodule

//--- rtl/gear_pattern_src.sv
// Pattern pair source

`timescale 1ns/1ps

module gear_pattern_src import gear_pkg::*; #(
  parameter int BIG_ENDIAN = 0
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_load,
  input  word_t      i_seed,
  input  logic       i_corrupt,
  input  logic       i_emit,
  output gear_pair_t o_pair
);

  word_t next_q;
  logic  flip_q;
  logic  valid_q;
  word_t word0_q;
  word_t word1_q;
  word_t first_w;
  word_t second_w;

  // Bit 0 of the first word flips once per corrupted burst
  assign first_w  = next_q ^ word_t'(flip_q);
  assign second_w = next_q + word_t'(1);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      next_q  <= '0;
      flip_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_emit;
      if (i_load) begin
        next_q <= i_seed;
        flip_q <= i_corrupt;
      end else if (i_emit) begin
        next_q <= next_q + word_t'(2);
        flip_q <= 1'b0;
      end
    end
  end

  // Earlier word in the low lane unless big endian
  always_ff @(posedge i_clk) begin
    if (i_emit) begin
      word0_q <= (BIG_ENDIAN != 0) ? second_w : first_w;
      word1_q <= (BIG_ENDIAN != 0) ? first_w : second_w;
    end
  end

  assign o_pair = '{valid: valid_q, word1: word1_q, word0: word0_q};

endmodule

//--- rtl/gear_burst_counter.sv
// Burst and drain down-counter

`timescale 1ns/1ps

module gear_burst_counter (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_load,
  input  logic [15:0] i_value,
  input  logic        i_en,
  output logic        o_last
);

  logic [15:0] count_q;

  // Load wins over a count step
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      count_q <= '0;
    end else if (i_load) begin
      count_q <= i_value;
    end else if (i_en && (count_q != 16'd0)) begin
      // Stops at zero
      count_q <= count_q - 16'd1;
    end
  end

  // Final count, also true once run dry
  assign o_last = (count_q <= 16'd1);

endmodule

//--- rtl/gear_seq_fsm.sv
// Burst sequencer

`timescale 1ns/1ps

module gear_seq_fsm import gear_pkg::*; #(
  parameter int DRAIN_CYCLES = 32
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_start,
  input  logic [15:0] i_len,
  input  logic        i_cnt_last,
  input  logic [15:0] i_rx_pairs,
  output logic        o_cnt_load,
  output logic [15:0] o_cnt_value,
  output logic        o_cnt_en,
  output logic        o_src_load,
  output logic        o_src_emit,
  output logic        o_chk_clear,
  output logic        o_busy,
  output logic        o_done,
  output logic        o_timeout
);

  localparam logic [15:0] DRAIN_VALUE = 16'(DRAIN_CYCLES);

  seq_state_e  state_q;
  logic [15:0] len_q;
  logic [15:0] len_eff;
  logic        done_q;
  logic        timeout_q;

  // Zero length runs a single pair
  assign len_eff = (i_len == 16'd0) ? 16'd1 : i_len;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q   <= S_IDLE;
      len_q     <= 16'd1;
      done_q    <= 1'b0;
      timeout_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (i_start) begin
            state_q   <= S_RUN;
            len_q     <= len_eff;
            done_q    <= 1'b0;
            timeout_q <= 1'b0;
          end
        end
        S_RUN: begin
          if (i_cnt_last) state_q <= S_DRAIN;
        end
        S_DRAIN: begin
          // All pairs back wins over the timer
          if (i_rx_pairs == len_q) begin
            state_q <= S_DONE;
          end else if (i_cnt_last) begin
            timeout_q <= 1'b1;
            state_q   <= S_DONE;
          end
        end
        S_DONE: begin
          done_q  <= 1'b1;
          state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Counter, source and checker strobes
  always_comb begin
    o_cnt_load  = 1'b0;
    o_cnt_value = len_eff;
    o_cnt_en    = 1'b0;
    o_src_load  = 1'b0;
    o_src_emit  = 1'b0;
    o_chk_clear = 1'b0;
    case (state_q)
      S_IDLE: begin
        o_cnt_load  = i_start;
        o_src_load  = i_start;
        o_chk_clear = i_start;
      end
      S_RUN: begin
        o_src_emit  = 1'b1;
        o_cnt_en    = 1'b1;
        // Counter turns into the drain timer as the last pair goes out
        o_cnt_load  = i_cnt_last;
        o_cnt_value = DRAIN_VALUE;
      end
      S_DRAIN: o_cnt_en = 1'b1;
      default: ;
    endcase
  end

  assign o_busy    = (state_q != S_IDLE);
  assign o_done    = done_q || (state_q == S_DONE);
  assign o_timeout = timeout_q;

  a_emit_run: assert property (@(posedge i_clk) disable iff (i_rst)
    o_src_emit |-> state_q == S_RUN);

endmodule

//--- rtl/gear_csr.sv
// Loop control registers

`timescale 1ns/1ps

module gear_csr import gear_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  input  axil_req_t   i_axil,
  output axil_rsp_t   o_axil,
  output logic        o_start,
  output logic        o_corrupt,
  output logic [15:0] o_len,
  output word_t       o_seed,
  input  logic        i_busy,
  input  logic        i_done,
  input  logic        i_timeout,
  input  logic [15:0] i_pairs,
  input  logic [15:0] i_errors
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic        wr_rdy_q;
  logic        b_valid_q;
  logic [1:0]  b_resp_q;
  logic        rd_rdy_q;
  logic        r_valid_q;
  logic [1:0]  r_resp_q;
  logic [31:0] r_data_q;
  logic        start_q;
  logic        corrupt_q;
  logic [15:0] len_q;
  word_t       seed_q;
  logic        wr_fire;
  logic        rd_fire;

  // Address lies in the register map
  function automatic logic addr_known(input logic [7:0] addr);
    case (addr)
      REG_CTRL, REG_LEN, REG_SEED, REG_STATUS, REG_PAIRS, REG_ERRORS: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign wr_fire = wr_rdy_q && i_axil.aw_valid && i_axil.w_valid;
  assign rd_fire = rd_rdy_q && i_axil.ar_valid;

  // --------------------------------------------------------------------------
  // Write channel
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_rdy_q  <= 1'b0;
      b_valid_q <= 1'b0;
      b_resp_q  <= RESP_OKAY;
      start_q   <= 1'b0;
      corrupt_q <= 1'b0;
      len_q     <= '0;
      seed_q    <= '0;
    end else begin
      // Start lasts one cycle
      start_q  <= 1'b0;
      // AW and W taken together, ready for a single cycle
      wr_rdy_q <= i_axil.aw_valid && i_axil.w_valid && !wr_rdy_q && !b_valid_q;
      if (b_valid_q && i_axil.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (wr_fire) begin
        b_valid_q <= 1'b1;
        b_resp_q  <= addr_known(i_axil.aw_addr) ? RESP_OKAY : RESP_SLVERR;
        case (csr_addr_e'(i_axil.aw_addr))
          REG_CTRL: begin
            if (i_axil.w_strb[0]) begin
              // Start while a burst runs is dropped
              start_q   <= i_axil.w_data[0] && !i_busy;
              corrupt_q <= i_axil.w_data[1];
            end
          end
          REG_LEN: begin
            if (i_axil.w_strb[0]) len_q[7:0] <= i_axil.w_data[7:0];
            if (i_axil.w_strb[1]) len_q[15:8] <= i_axil.w_data[15:8];
          end
          REG_SEED: begin
            if (i_axil.w_strb[0]) seed_q[7:0] <= i_axil.w_data[7:0];
            if (i_axil.w_strb[1]) seed_q[15:8] <= i_axil.w_data[15:8];
          end
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read channel
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_rdy_q  <= 1'b0;
      r_valid_q <= 1'b0;
      r_resp_q  <= RESP_OKAY;
    end else begin
      rd_rdy_q <= i_axil.ar_valid && !rd_rdy_q && !r_valid_q;
      if (r_valid_q && i_axil.r_ready) begin
        r_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
        r_resp_q  <= addr_known(i_axil.ar_addr) ? RESP_OKAY : RESP_SLVERR;
      end
    end
  end

  // Read data, live status and counters
  always_ff @(posedge i_clk) begin
    if (rd_fire) begin
      case (csr_addr_e'(i_axil.ar_addr))
        REG_CTRL:   r_data_q <= {30'd0, corrupt_q, 1'b0};
        REG_LEN:    r_data_q <= {16'd0, len_q};
        REG_SEED:   r_data_q <= {16'd0, seed_q};
        REG_STATUS: r_data_q <= {29'd0, i_timeout, i_done, i_busy};
        REG_PAIRS:  r_data_q <= {16'd0, i_pairs};
        REG_ERRORS: r_data_q <= {16'd0, i_errors};
        default:    r_data_q <= '0;
      endcase
    end
  end

  assign o_axil.aw_ready = wr_rdy_q;
  assign o_axil.w_ready  = wr_rdy_q;
  assign o_axil.b_valid  = b_valid_q;
  assign o_axil.b_resp   = b_resp_q;
  assign o_axil.ar_ready = rd_rdy_q;
  assign o_axil.r_valid  = r_valid_q;
  assign o_axil.r_data   = r_data_q;
  assign o_axil.r_resp   = r_resp_q;

  assign o_start   = start_q;
  assign o_corrupt = corrupt_q;
  assign o_len     = len_q;
  assign o_seed    = seed_q;

  // Write response is held until the master takes it
  a_b_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    b_valid_q && !i_axil.b_ready |=> b_valid_q);

endmodule

//--- rtl/gear_pkg.sv
// Gearbox loop shared types

package gear_pkg;

  // Word width is fixed here so the structs can use it
  localparam int WORD_W = 16;

  typedef logic [WORD_W-1:0] word_t;

  // Slow-side pair; word0 is the low half of the gearbox lane vector
  typedef struct packed {
    logic  valid;
    word_t word1;
    word_t word0;
  } gear_pair_t;

  // Fast-side word, one per 2x cycle
  typedef struct packed {
    logic  valid;
    word_t data;
  } gear_word_t;

  // AXI4-Lite master to slave
  typedef struct packed {
    logic        aw_valid;
    logic [7:0]  aw_addr;
    logic        w_valid;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        b_ready;
    logic        ar_valid;
    logic [7:0]  ar_addr;
    logic        r_ready;
  } axil_req_t;

  // AXI4-Lite slave to master
  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    logic        b_valid;
    logic [1:0]  b_resp;
    logic        ar_ready;
    logic        r_valid;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
  } axil_rsp_t;

  // Register map
  typedef enum logic [7:0] {
    REG_CTRL   = 8'h00,
    REG_LEN    = 8'h04,
    REG_SEED   = 8'h08,
    REG_STATUS = 8'h0C,
    REG_PAIRS  = 8'h10,
    REG_ERRORS = 8'h14
  } csr_addr_e;

  // Burst sequencer states
  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_DRAIN,
    S_DONE
  } seq_state_e;

endpackage
